// ==== source/dma_cfg_pkg.sv ====
package dma_cfg_pkg;

    // Memory word
    localparam int DATA_W = 32;
    localparam int BYTES_W = DATA_W / 8;
    localparam int OFFSET_W = $clog2(BYTES_W); // Byte lane select

    // Job description
    localparam int ADDR_W = 16; // Byte address
    localparam int LEN_W = 8;   // Length in whole words

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [LEN_W-1:0] len_t;

endpackage

// ==== source/apb_map_pkg.sv ====
package apb_map_pkg;

    localparam int APB_ADDR_W = 4;

    // Register offsets
    localparam logic [APB_ADDR_W-1:0] REG_SRC_ADDR = 4'h0;
    localparam logic [APB_ADDR_W-1:0] REG_LEN = 4'h4;
    localparam logic [APB_ADDR_W-1:0] REG_CTRL = 4'h8;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'hC;

    localparam int CTRL_START_BIT = 0;

    // Status bits
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

// ==== source/word_stream_if.sv ====
interface word_stream_if;

    logic start;                 // One cycle at job start
    dma_cfg_pkg::offset_t offset; // Held for the whole job
    logic valid;
    dma_cfg_pkg::word_t data;
    logic last;                  // Final response of the job

    modport fetch (
        output start,
        output offset,
        output valid,
        output data,
        output last
    );

    modport align (
        input start,
        input offset,
        input valid,
        input data,
        input last
    );

endinterface

// ==== source/apb_regs.sv ====
module apb_regs (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [apb_map_pkg::APB_ADDR_W-1:0]  paddr_i,
    input  dma_cfg_pkg::word_t                  pwdata_i,
    output dma_cfg_pkg::word_t                  prdata_o,
    output logic                                job_start_o,
    output dma_cfg_pkg::addr_t                  job_addr_o,
    output dma_cfg_pkg::len_t                   job_len_o,
    input  logic                                job_done_i,
    output logic                                done_o
);

    dma_cfg_pkg::addr_t src_addr_q;
    dma_cfg_pkg::len_t len_q;
    logic busy;
    logic done;
    logic wr_en;
    logic start_req;

    assign wr_en = psel_i & penable_i & pwrite_i; // Access phase only

    // Start while busy is dropped here
    assign start_req = wr_en && (paddr_i == apb_map_pkg::REG_CTRL)
                       && pwdata_i[apb_map_pkg::CTRL_START_BIT] && !busy;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            src_addr_q <= '0;
            len_q <= '0;
            busy <= 1'b0;
            done <= 1'b0;
            job_start_o <= 1'b0;
        end else begin
            job_start_o <= 1'b0;

            if (wr_en && paddr_i == apb_map_pkg::REG_SRC_ADDR)
                src_addr_q <= pwdata_i[dma_cfg_pkg::ADDR_W-1:0];
            if (wr_en && paddr_i == apb_map_pkg::REG_LEN)
                len_q <= pwdata_i[dma_cfg_pkg::LEN_W-1:0];

            if (job_done_i) begin
                busy <= 1'b0;
                done <= 1'b1;
            end

            if (start_req) begin
                // Zero length finishes on the spot
                done <= (len_q == '0);
                busy <= (len_q != '0);
                job_start_o <= (len_q != '0);
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            apb_map_pkg::REG_SRC_ADDR: prdata_o = dma_cfg_pkg::word_t'(src_addr_q);
            apb_map_pkg::REG_LEN:      prdata_o = dma_cfg_pkg::word_t'(len_q);
            apb_map_pkg::REG_STATUS: begin
                prdata_o[apb_map_pkg::STATUS_BUSY_BIT] = busy;
                prdata_o[apb_map_pkg::STATUS_DONE_BIT] = done;
            end
            default: prdata_o = '0; // Control reads back as zero
        endcase
    end

    assign job_addr_o = src_addr_q;
    assign job_len_o = len_q;
    assign done_o = done;

    // Aligner may only finish a job that was started here
    a_done_only_when_busy: assert property (
        @(posedge clk_i) disable iff (rst_i) job_done_i |-> busy
    );

endmodule

// ==== source/word_fetcher.sv ====
module word_fetcher (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                job_start_i,
    input  dma_cfg_pkg::addr_t  job_addr_i,
    input  dma_cfg_pkg::len_t   job_len_i,
    output logic                mem_req_o,
    output dma_cfg_pkg::addr_t  mem_addr_o,
    input  logic                mem_gnt_i,
    input  logic                mem_rvalid_i,
    input  dma_cfg_pkg::word_t  mem_rdata_i,
    word_stream_if.fetch        stream
);

    // One extra bit, K can be LEN + 1
    logic [dma_cfg_pkg::LEN_W:0] word_cnt;
    logic [dma_cfg_pkg::LEN_W:0] req_left;
    logic [dma_cfg_pkg::LEN_W:0] rsp_left;
    dma_cfg_pkg::offset_t start_off;
    dma_cfg_pkg::offset_t offset_q;
    dma_cfg_pkg::addr_t req_addr;
    logic start_q;
    logic grant;

    assign start_off = job_addr_i[dma_cfg_pkg::OFFSET_W-1:0];

    // Unaligned start needs one more word
    assign word_cnt = {1'b0, job_len_i}
                      + {{dma_cfg_pkg::LEN_W{1'b0}}, (start_off != '0)};

    assign mem_req_o = (req_left != '0);
    assign mem_addr_o = req_addr;
    assign grant = mem_req_o & mem_gnt_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            req_left <= '0;
            rsp_left <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= job_start_i;
            if (job_start_i) begin
                req_left <= word_cnt;
                rsp_left <= word_cnt;
            end else begin
                if (grant)
                    req_left <= req_left - 1'b1;
                if (mem_rvalid_i && rsp_left != '0)
                    rsp_left <= rsp_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (job_start_i) begin
            req_addr <= {job_addr_i[dma_cfg_pkg::ADDR_W-1:dma_cfg_pkg::OFFSET_W],
                         {dma_cfg_pkg::OFFSET_W{1'b0}}};
            offset_q <= start_off;
        end else if (grant) begin
            req_addr <= req_addr + dma_cfg_pkg::addr_t'(dma_cfg_pkg::BYTES_W);
        end
    end

    // Start goes out with the first request, ahead of any response
    assign stream.start = start_q;
    assign stream.offset = offset_q;
    assign stream.valid = mem_rvalid_i;
    assign stream.data = mem_rdata_i;
    assign stream.last = mem_rvalid_i && (rsp_left == 'd1);

    // Granted minus answered is rsp_left - req_left
    a_rsp_needs_outstanding: assert property (
        @(posedge clk_i) disable iff (rst_i) mem_rvalid_i |-> (rsp_left > req_left)
    );

endmodule

// ==== source/burst_align.sv ====
module burst_align (
    input  logic                clk_i,
    input  logic                rst_i,
    word_stream_if.align        stream,
    output dma_cfg_pkg::word_t  out_data_o,
    output logic                out_valid_o,
    output logic                job_done_o
);

    dma_cfg_pkg::word_t stored_data;
    logic [2*dma_cfg_pkg::DATA_W-1:0] joined;
    logic have_prev; // Stored word belongs to this job
    logic in_job;
    logic flush;
    logic zero_off;

    assign zero_off = (stream.offset == '0);

    // New word above the stored one, window starts at the byte offset
    assign joined = {stream.data, stored_data};
    assign out_data_o = joined[{stream.offset, 3'b000} +: dma_cfg_pkg::DATA_W];

    assign out_valid_o = (in_job & have_prev & stream.valid) | flush;

    // Aligned jobs end on the flush, others on the last response
    assign job_done_o = flush | (stream.valid & stream.last & ~zero_off);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            have_prev <= 1'b0;
            in_job <= 1'b0;
            flush <= 1'b0;
        end else begin
            flush <= stream.valid & stream.last & zero_off;

            if (stream.start) begin
                in_job <= 1'b1;
                have_prev <= 1'b0;
            end

            if (stream.valid) begin
                have_prev <= 1'b1;
                if (stream.last)
                    in_job <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (stream.valid)
            stored_data <= stream.data;
    end

    // Fetcher must announce the job before data shows up
    a_valid_after_start: assert property (
        @(posedge clk_i) disable iff (rst_i) stream.valid |-> in_job
    );

endmodule

// ==== source/unaligned_reader.sv ====
module unaligned_reader (
    input  logic                                clk_i,
    input  logic                                rst_i,

    // APB slave
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [apb_map_pkg::APB_ADDR_W-1:0]  paddr_i,
    input  dma_cfg_pkg::word_t                  pwdata_i,
    output dma_cfg_pkg::word_t                  prdata_o,

    // Memory read port
    output logic                                mem_req_o,
    output dma_cfg_pkg::addr_t                  mem_addr_o,
    input  logic                                mem_gnt_i,
    input  logic                                mem_rvalid_i,
    input  dma_cfg_pkg::word_t                  mem_rdata_i,

    // Output stream, no ready
    output dma_cfg_pkg::word_t                  out_data_o,
    output logic                                out_valid_o,
    output logic                                done_o
);

    logic job_start;
    dma_cfg_pkg::addr_t job_addr;
    dma_cfg_pkg::len_t job_len;
    logic job_done;

    word_stream_if u_stream ();

    apb_regs u_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .job_start_o (job_start),
        .job_addr_o  (job_addr),
        .job_len_o   (job_len),
        .job_done_i  (job_done),
        .done_o      (done_o)
    );

    word_fetcher u_fetcher (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .job_start_i  (job_start),
        .job_addr_i   (job_addr),
        .job_len_i    (job_len),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .stream       (u_stream.fetch)
    );

    burst_align u_align (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stream      (u_stream.align),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .job_done_o  (job_done)
    );

endmodule

// ==== sim/tb_mem_model.sv ====
module tb_mem_model (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               mem_req_i,
    input  dma_cfg_pkg::addr_t mem_addr_i,
    output logic               mem_gnt_o,
    output logic               mem_rvalid_o,
    output dma_cfg_pkg::word_t mem_rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    integer seed = 32'hbfb1_77de;
    dma_cfg_pkg::word_t data_q[$];
    int due_q[$];
    int cycle;
    int last_due;
    int due;

    // Byte a holds a * 7 + 3, low 8 bits
    function automatic dma_cfg_pkg::word_t fill_word(dma_cfg_pkg::addr_t addr);
        dma_cfg_pkg::word_t w;
        dma_cfg_pkg::addr_t prod;
        for (int j = 0; j < dma_cfg_pkg::BYTES_W; j++) begin
            prod = (addr + dma_cfg_pkg::addr_t'(j)) * 16'd7 + 16'd3;
            w[8*j +: 8] = prod[7:0];
        end
        return w;
    endfunction

    always @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            mem_gnt_o <= 1'b0;
            mem_rvalid_o <= 1'b0;
            mem_rdata_o <= '0;
            data_q.delete();
            due_q.delete();
            cycle = 0;
            last_due = 0;
        end else begin
            cycle = cycle + 1;
            if (mem_req_i && mem_gnt_o) begin
                due = cycle + 1 + ({$random(seed)} % 4);
                if (due <= last_due)
                    due = last_due + 1; // Keep order, one per cycle
                last_due = due;
                due_q.push_back(due);
                data_q.push_back(fill_word(mem_addr_i));
            end

            // Waiting request gets its grant next cycle
            if (mem_req_i && !mem_gnt_o)
                mem_gnt_o <= 1'b1;
            else
                mem_gnt_o <= ($random(seed) & 1) != 0;

            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                mem_rvalid_o <= 1'b1;
                mem_rdata_o <= data_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                mem_rvalid_o <= 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_unaligned_reader.sv ====
module tb_unaligned_reader;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DONE_TIMEOUT = 400;

    logic clk;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [apb_map_pkg::APB_ADDR_W-1:0] paddr;
    dma_cfg_pkg::word_t pwdata;
    dma_cfg_pkg::word_t prdata;
    logic mem_req;
    dma_cfg_pkg::addr_t mem_addr;
    logic mem_gnt;
    logic mem_rvalid;
    dma_cfg_pkg::word_t mem_rdata;
    dma_cfg_pkg::word_t out_data;
    logic out_valid;
    logic done;

    integer seed = 32'hbfb1_77de;
    int error_count;
    int check_total;
    dma_cfg_pkg::word_t got_q[$];
    dma_cfg_pkg::addr_t req_q[$];
    dma_cfg_pkg::len_t lens[2] = '{8'd1, 8'd4};

    unaligned_reader u_dut (
        .clk_i(clk), .rst_i(rst),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
        .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_gnt_i(mem_gnt),
        .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata),
        .out_data_o(out_data), .out_valid_o(out_valid), .done_o(done)
    );

    tb_mem_model u_mem (
        .clk_i(clk), .rst_i(rst),
        .mem_req_i(mem_req), .mem_addr_i(mem_addr), .mem_gnt_o(mem_gnt),
        .mem_rvalid_o(mem_rvalid), .mem_rdata_o(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && out_valid)
            got_q.push_back(out_data);
        if (!rst && mem_req && mem_gnt)
            req_q.push_back(mem_addr); // Accepted requests
    end

    function automatic dma_cfg_pkg::word_t expected_word(dma_cfg_pkg::addr_t src, int idx);
        dma_cfg_pkg::word_t w;
        dma_cfg_pkg::addr_t a;
        dma_cfg_pkg::addr_t prod;
        for (int j = 0; j < dma_cfg_pkg::BYTES_W; j++) begin
            a = src + dma_cfg_pkg::addr_t'(dma_cfg_pkg::BYTES_W * idx + j);
            prod = a * 16'd7 + 16'd3;
            w[8*j +: 8] = prod[7:0]; // Lowest address in the low byte
        end
        return w;
    endfunction

    task automatic check_word(input string name, input dma_cfg_pkg::word_t exp,
                              input dma_cfg_pkg::word_t act);
        check_total++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input dma_cfg_pkg::addr_t exp,
                              input dma_cfg_pkg::addr_t act);
        check_total++;
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_status(input string name, input dma_cfg_pkg::word_t exp,
                                input dma_cfg_pkg::word_t act);
        check_total++;
        if (act !== exp) begin
            $display("mismatch %s register: expected %h, actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        check_total++;
        if (act != exp) begin
            $display("mismatch %s count: expected %0d, actual %0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic apb_write(input logic [apb_map_pkg::APB_ADDR_W-1:0] addr,
                             input dma_cfg_pkg::word_t data);
        @(posedge clk);
        psel <= 1'b1;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic apb_read(input logic [apb_map_pkg::APB_ADDR_W-1:0] addr,
                            output dma_cfg_pkg::word_t data);
        @(posedge clk);
        psel <= 1'b1;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        data = prdata; // Access phase value
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic program_job(input dma_cfg_pkg::addr_t src, input dma_cfg_pkg::len_t len);
        got_q.delete();
        req_q.delete();
        apb_write(apb_map_pkg::REG_SRC_ADDR, dma_cfg_pkg::word_t'(src));
        apb_write(apb_map_pkg::REG_LEN, dma_cfg_pkg::word_t'(len));
        apb_write(apb_map_pkg::REG_CTRL, 32'd1 << apb_map_pkg::CTRL_START_BIT);
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (done !== 1'b1 && cycles < DONE_TIMEOUT);
        if (done !== 1'b1) begin
            $display("timeout in %s: done_o never rose", name);
            error_count++;
        end
    endtask

    task automatic finish_job(input string name, input dma_cfg_pkg::addr_t src,
                              input dma_cfg_pkg::len_t len);
        int fetch_cnt;
        dma_cfg_pkg::addr_t base;
        // One extra word when the start is not on a word boundary
        fetch_cnt = int'(len) + (((src % dma_cfg_pkg::BYTES_W) != 0) ? 1 : 0);
        base = src - (src % dma_cfg_pkg::BYTES_W);
        wait_done(name);
        check_count({name, " words"}, int'(len), got_q.size());
        for (int i = 0; i < got_q.size() && i < int'(len); i++)
            check_word($sformatf("%s word %0d", name, i), expected_word(src, i), got_q[i]);
        check_count({name, " requests"}, fetch_cnt, req_q.size());
        for (int i = 0; i < req_q.size() && i < fetch_cnt; i++)
            check_addr($sformatf("%s request %0d", name, i),
                       base + dma_cfg_pkg::addr_t'(dma_cfg_pkg::BYTES_W * i), req_q[i]);
    endtask

    task automatic test_reset();
        dma_cfg_pkg::word_t v;
        apb_read(apb_map_pkg::REG_STATUS, v);
        check_status("reset status", 32'h0, v);
        apb_read(apb_map_pkg::REG_SRC_ADDR, v);
        check_status("reset address", 32'h0, v);
    endtask

    task automatic test_aligned();
        dma_cfg_pkg::word_t v;
        program_job(16'h0100, 8'd5);
        finish_job("aligned", 16'h0100, 8'd5);
        apb_read(apb_map_pkg::REG_STATUS, v);
        check_status("aligned status", 32'd1 << apb_map_pkg::STATUS_DONE_BIT, v);
    endtask

    task automatic test_unaligned();
        dma_cfg_pkg::addr_t src;
        for (int off = 1; off < 4; off++) begin
            foreach (lens[k]) begin
                src = dma_cfg_pkg::addr_t'(16'h0240 + 16'h40 * off + off);
                program_job(src, lens[k]);
                finish_job($sformatf("unaligned off %0d len %0d", off, lens[k]), src, lens[k]);
            end
        end
    endtask

    task automatic test_start_while_busy();
        dma_cfg_pkg::word_t v;
        program_job(16'h0405, 8'd8);
        apb_write(apb_map_pkg::REG_CTRL, 32'd1 << apb_map_pkg::CTRL_START_BIT);
        apb_read(apb_map_pkg::REG_STATUS, v);
        check_status("busy start status", 32'd1 << apb_map_pkg::STATUS_BUSY_BIT, v);
        finish_job("busy start", 16'h0405, 8'd8);
        repeat (16) @(posedge clk);
        check_count("busy start trailing words", 8, got_q.size());
    endtask

    task automatic test_zero_length();
        dma_cfg_pkg::word_t v;
        // Done must start out clear to see the zero-length start set it
        apb_read(apb_map_pkg::REG_STATUS, v);
        check_status("zero length idle status", 32'h0, v);
        program_job(16'h0600, 8'd0);
        wait_done("zero length");
        repeat (8) @(posedge clk);
        check_count("zero length words", 0, got_q.size());
        check_count("zero length requests", 0, req_q.size());
        apb_read(apb_map_pkg::REG_STATUS, v);
        check_status("zero length status", 32'd1 << apb_map_pkg::STATUS_DONE_BIT, v);
    endtask

    task automatic test_random_jobs();
        dma_cfg_pkg::addr_t src;
        dma_cfg_pkg::len_t len;
        for (int n = 0; n < 3; n++) begin
            src = dma_cfg_pkg::addr_t'($random(seed)) & 16'h3fff;
            len = dma_cfg_pkg::len_t'(1 + {$random(seed)} % 8);
            program_job(src, len);
            finish_job($sformatf("random job %0d", n), src, len);
        end
    endtask

    initial begin
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        error_count = 0;
        check_total = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_reset();
        test_zero_length();
        test_aligned();
        test_unaligned();
        test_start_while_busy();
        test_random_jobs();

        $display("summary: %0d checks, %0d errors", check_total, error_count);
        if (error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
source/dma_cfg_pkg.sv
source/apb_map_pkg.sv
source/word_stream_if.sv
source/apb_regs.sv
source/word_fetcher.sv
source/burst_align.sv
source/unaligned_reader.sv
sim/tb_mem_model.sv
sim/tb_unaligned_reader.sv
